// File: Bender.yml
package:
  name: mips_pipe_cpu

sources:
  - files:
      - hw/cpu_isa_pkg.sv
      - hw/cpu_pipe_pkg.sv
      - hw/fetch_stage.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/memory_stage.sv
      - hw/cpu.sv
  - target: test
    files:
      - testbench/cpu_checker.sv
      - testbench/cpu_tb.sv

// File: build.f
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// File: hw/cpu.sv
`timescale 1ns/1ps

module cpu (
	input  logic                          clk,
	input  logic                          reset,
	// Instruction port
	output logic [cpu_pipe_pkg::xlen-1:0] imem_addr,
	input  logic [cpu_pipe_pkg::xlen-1:0] imem_data,
	// Data port
	output logic                          mem_enable,
	output logic                          mem_rw,
	output logic [cpu_pipe_pkg::xlen-1:0] mem_addr,
	output logic [cpu_pipe_pkg::xlen-1:0] mem_data_in,
	input  logic [cpu_pipe_pkg::xlen-1:0] mem_data_out,
	input  logic                          mem_ack
);

	////////////////////////////////////////
	// Hazard and redirect wires
	////////////////////////////////////////

	logic jump_taken, branch_taken, load_stall, mem_stall;
	logic [cpu_pipe_pkg::xlen-1:0] jump_target, branch_target;

	////////////////////////////////////////
	// Stage to stage
	////////////////////////////////////////

	logic [cpu_pipe_pkg::xlen-1:0] d_instr, d_pc_next;
	logic e_regwrite, e_memread, e_memwrite, e_isbranch, e_alusrc, e_regdst;
	cpu_pipe_pkg::alu_op_t e_alu_op;
	logic [cpu_pipe_pkg::xlen-1:0] e_rs_data, e_rt_data, e_pc_next;
	logic [15:0] e_imm;
	logic [cpu_pipe_pkg::reg_addr_w-1:0] e_rt, e_rd;
	logic [cpu_pipe_pkg::xlen-1:0] ex_result, m_result, m_store_data;
	logic [cpu_pipe_pkg::reg_addr_w-1:0] ex_wreg, m_wreg;
	logic ex_regwrite, ex_memread, m_regwrite, m_memread, m_memwrite;
	logic [cpu_pipe_pkg::xlen-1:0] mem_fwd_data, wb_wdata;
	logic [cpu_pipe_pkg::reg_addr_w-1:0] mem_fwd_wreg, wb_wreg;
	logic mem_fwd_regwrite, wb_regwrite;

	fetch_stage fetch_i (
		.clk, .reset, .jump_taken, .jump_target, .branch_taken, .branch_target,
		.load_stall, .mem_stall, .imem_data, .imem_addr, .d_instr, .d_pc_next
	);

	decode_stage decode_i (
		.clk, .reset, .d_instr, .d_pc_next, .branch_taken, .mem_stall,
		.ex_result, .ex_wreg, .ex_regwrite, .ex_memread,
		.mem_fwd_data, .mem_fwd_wreg, .mem_fwd_regwrite,
		.wb_regwrite, .wb_wreg, .wb_wdata,
		.jump_taken, .jump_target, .load_stall,
		.e_regwrite, .e_memread, .e_memwrite, .e_isbranch, .e_alusrc, .e_regdst,
		.e_alu_op, .e_rs_data, .e_rt_data, .e_imm, .e_rt, .e_rd, .e_pc_next
	);

	execute_stage execute_i (
		.clk, .reset, .mem_stall,
		.e_regwrite, .e_memread, .e_memwrite, .e_isbranch, .e_alusrc, .e_regdst,
		.e_alu_op, .e_rs_data, .e_rt_data, .e_imm, .e_rt, .e_rd, .e_pc_next,
		.branch_taken, .branch_target, .ex_result, .ex_wreg, .ex_regwrite, .ex_memread,
		.m_regwrite, .m_memread, .m_memwrite, .m_result, .m_store_data, .m_wreg
	);

	memory_stage memory_i (
		.clk, .reset, .m_regwrite, .m_memread, .m_memwrite, .m_result, .m_store_data,
		.m_wreg, .mem_data_out, .mem_ack,
		.mem_enable, .mem_rw, .mem_addr, .mem_data_in, .mem_stall,
		.mem_fwd_data, .mem_fwd_wreg, .mem_fwd_regwrite,
		.wb_regwrite, .wb_wreg, .wb_wdata
	);

endmodule

// File: hw/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// Primary opcodes, bits 31:26
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j       = 6'h02;
	localparam logic [5:0] op_beq     = 6'h04;
	localparam logic [5:0] op_addiu   = 6'h09;
	localparam logic [5:0] op_lw      = 6'h23;
	localparam logic [5:0] op_sw      = 6'h2b;

	// Function codes for op_special, bits 5:0
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_slt  = 6'h2a;

	// Register format
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	// Immediate format
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	// Jump format
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_fields_t;

	// One instruction word, three ways of reading it
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} instr_t;

endpackage

// File: hw/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

	// Data path and address width
	localparam int xlen = 32;

	// Register index width
	localparam int reg_addr_w = 5;

	// First fetch address out of reset
	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

	// ALU function, picked in decode
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4
	} alu_op_t;

	// Where a decode operand comes from
	typedef enum logic [1:0] {
		fwd_reg = 2'd0,
		fwd_ex  = 2'd1,
		fwd_mem = 2'd2,
		fwd_wb  = 2'd3
	} fwd_sel_t;

endpackage

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [cpu_pipe_pkg::xlen-1:0]       d_instr,
	input  logic [cpu_pipe_pkg::xlen-1:0]       d_pc_next,
	input  logic                                branch_taken,
	input  logic                                mem_stall,
	input  logic [cpu_pipe_pkg::xlen-1:0]       ex_result,
	input  logic [cpu_pipe_pkg::reg_addr_w-1:0] ex_wreg,
	input  logic                                ex_regwrite,
	input  logic                                ex_memread,
	input  logic [cpu_pipe_pkg::xlen-1:0]       mem_fwd_data,
	input  logic [cpu_pipe_pkg::reg_addr_w-1:0] mem_fwd_wreg,
	input  logic                                mem_fwd_regwrite,
	input  logic                                wb_regwrite,
	input  logic [cpu_pipe_pkg::reg_addr_w-1:0] wb_wreg,
	input  logic [cpu_pipe_pkg::xlen-1:0]       wb_wdata,
	output logic                                jump_taken,
	output logic [cpu_pipe_pkg::xlen-1:0]       jump_target,
	output logic                                load_stall,
	output logic                                e_regwrite,
	output logic                                e_memread,
	output logic                                e_memwrite,
	output logic                                e_isbranch,
	output logic                                e_alusrc,
	output logic                                e_regdst,
	output cpu_pipe_pkg::alu_op_t               e_alu_op,
	output logic [cpu_pipe_pkg::xlen-1:0]       e_rs_data,
	output logic [cpu_pipe_pkg::xlen-1:0]       e_rt_data,
	output logic [15:0]                         e_imm,
	output logic [cpu_pipe_pkg::reg_addr_w-1:0] e_rt,
	output logic [cpu_pipe_pkg::reg_addr_w-1:0] e_rd,
	output logic [cpu_pipe_pkg::xlen-1:0]       e_pc_next
);

	cpu_isa_pkg::instr_t instr;
	logic regwrite, memread, memwrite, isbranch, alusrc, regdst;
	logic is_jump, use_rs, use_rt;
	cpu_pipe_pkg::alu_op_t alu_op;
	cpu_pipe_pkg::fwd_sel_t sel_rs, sel_rt;
	logic [cpu_pipe_pkg::xlen-1:0] regs [32];
	logic [cpu_pipe_pkg::xlen-1:0] reg_rs, reg_rt, rs_data, rt_data;

	assign instr = d_instr;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_comb begin
		{regwrite, memread, memwrite, isbranch, alusrc, regdst} = '0;
		{is_jump, use_rs, use_rt} = '0;
		alu_op = cpu_pipe_pkg::alu_add;
		case (instr.r.opcode)
			cpu_isa_pkg::op_special: begin
				{use_rs, use_rt, regdst} = 3'b111;
				regwrite = 1'b1;
				case (instr.r.funct)
					cpu_isa_pkg::fn_addu: alu_op = cpu_pipe_pkg::alu_add;
					cpu_isa_pkg::fn_subu: alu_op = cpu_pipe_pkg::alu_sub;
					cpu_isa_pkg::fn_and:  alu_op = cpu_pipe_pkg::alu_and;
					cpu_isa_pkg::fn_or:   alu_op = cpu_pipe_pkg::alu_or;
					cpu_isa_pkg::fn_slt:  alu_op = cpu_pipe_pkg::alu_slt;
					// Unknown function codes and the zero word are nops
					default: regwrite = 1'b0;
				endcase
			end
			cpu_isa_pkg::op_addiu: {regwrite, alusrc, use_rs} = 3'b111;
			cpu_isa_pkg::op_lw:    {regwrite, memread, alusrc, use_rs} = 4'b1111;
			cpu_isa_pkg::op_sw:    {memwrite, alusrc, use_rs, use_rt} = 4'b1111;
			cpu_isa_pkg::op_beq: begin
				{isbranch, use_rs, use_rt} = 3'b111;
				alu_op = cpu_pipe_pkg::alu_sub;
			end
			cpu_isa_pkg::op_j:     is_jump = 1'b1;
			default: ;
		endcase
	end

	assign jump_taken = is_jump;
	assign jump_target = {d_pc_next[31:28], instr.j.target, 2'b00};

	// Load in execute feeding this instruction
	assign load_stall = ex_memread && ex_wreg != '0 &&
		((use_rs && ex_wreg == instr.r.rs) || (use_rt && ex_wreg == instr.r.rt));

	////////////////////////////////////////
	// Register file and forwarding
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wb_regwrite && wb_wreg != '0)
			regs[wb_wreg] <= wb_wdata;
	end

	assign reg_rs = (instr.r.rs == '0) ? '0 : regs[instr.r.rs];
	assign reg_rt = (instr.r.rt == '0) ? '0 : regs[instr.r.rt];

	// Youngest producer wins and write-back covers the same-cycle write
	function automatic cpu_pipe_pkg::fwd_sel_t pick_src(
		input logic [cpu_pipe_pkg::reg_addr_w-1:0] r
	);
		if (r == '0)
			return cpu_pipe_pkg::fwd_reg;
		if (ex_regwrite && !ex_memread && ex_wreg == r)
			return cpu_pipe_pkg::fwd_ex;
		if (mem_fwd_regwrite && mem_fwd_wreg == r)
			return cpu_pipe_pkg::fwd_mem;
		if (wb_regwrite && wb_wreg == r)
			return cpu_pipe_pkg::fwd_wb;
		return cpu_pipe_pkg::fwd_reg;
	endfunction

	function automatic logic [cpu_pipe_pkg::xlen-1:0] operand(
		input cpu_pipe_pkg::fwd_sel_t sel,
		input logic [cpu_pipe_pkg::xlen-1:0] from_reg
	);
		case (sel)
			cpu_pipe_pkg::fwd_ex:  return ex_result;
			cpu_pipe_pkg::fwd_mem: return mem_fwd_data;
			cpu_pipe_pkg::fwd_wb:  return wb_wdata;
			default:               return from_reg;
		endcase
	endfunction

	assign sel_rs = pick_src(instr.r.rs);
	assign sel_rt = pick_src(instr.r.rt);
	assign rs_data = operand(sel_rs, reg_rs);
	assign rt_data = operand(sel_rt, reg_rt);

	////////////////////////////////////////
	// Decode/execute register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || (!mem_stall && (load_stall || branch_taken))) begin
			{e_regwrite, e_memread, e_memwrite, e_isbranch, e_alusrc, e_regdst} <= '0;
			e_alu_op <= cpu_pipe_pkg::alu_add;
		end else if (!mem_stall) begin
			{e_regwrite, e_memread, e_memwrite} <= {regwrite, memread, memwrite};
			{e_isbranch, e_alusrc, e_regdst} <= {isbranch, alusrc, regdst};
			e_alu_op <= alu_op;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			e_rs_data <= rs_data;
			e_rt_data <= rt_data;
			e_imm <= instr.i.imm;
			e_rt <= instr.r.rt;
			e_rd <= instr.r.rd;
			e_pc_next <= d_pc_next;
		end
	end

	// Load-use stall lasts one cycle
	a_load_stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
		(load_stall && !mem_stall) |=> !load_stall);

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                mem_stall,
	input  logic                                e_regwrite,
	input  logic                                e_memread,
	input  logic                                e_memwrite,
	input  logic                                e_isbranch,
	input  logic                                e_alusrc,
	input  logic                                e_regdst,
	input  cpu_pipe_pkg::alu_op_t               e_alu_op,
	input  logic [cpu_pipe_pkg::xlen-1:0]       e_rs_data,
	input  logic [cpu_pipe_pkg::xlen-1:0]       e_rt_data,
	input  logic [15:0]                         e_imm,
	input  logic [cpu_pipe_pkg::reg_addr_w-1:0] e_rt,
	input  logic [cpu_pipe_pkg::reg_addr_w-1:0] e_rd,
	input  logic [cpu_pipe_pkg::xlen-1:0]       e_pc_next,
	output logic                                branch_taken,
	output logic [cpu_pipe_pkg::xlen-1:0]       branch_target,
	output logic [cpu_pipe_pkg::xlen-1:0]       ex_result,
	output logic [cpu_pipe_pkg::reg_addr_w-1:0] ex_wreg,
	output logic                                ex_regwrite,
	output logic                                ex_memread,
	output logic                                m_regwrite,
	output logic                                m_memread,
	output logic                                m_memwrite,
	output logic [cpu_pipe_pkg::xlen-1:0]       m_result,
	output logic [cpu_pipe_pkg::xlen-1:0]       m_store_data,
	output logic [cpu_pipe_pkg::reg_addr_w-1:0] m_wreg
);

	logic [cpu_pipe_pkg::xlen-1:0] imm_ext;
	logic [cpu_pipe_pkg::xlen-1:0] alu_b;

	assign imm_ext = {{16{e_imm[15]}}, e_imm};
	assign alu_b = e_alusrc ? imm_ext : e_rt_data;

	always_comb begin
		case (e_alu_op)
			cpu_pipe_pkg::alu_sub: ex_result = e_rs_data - alu_b;
			cpu_pipe_pkg::alu_and: ex_result = e_rs_data & alu_b;
			cpu_pipe_pkg::alu_or:  ex_result = e_rs_data | alu_b;
			cpu_pipe_pkg::alu_slt:
				ex_result = {31'b0, $signed(e_rs_data) < $signed(alu_b)};
			default:               ex_result = e_rs_data + alu_b;
		endcase
	end

	// beq resolves here
	assign branch_taken = e_isbranch && (e_rs_data == e_rt_data);
	assign branch_target = e_pc_next + (imm_ext << 2);

	assign ex_wreg = e_regdst ? e_rd : e_rt;
	assign ex_regwrite = e_regwrite;
	assign ex_memread = e_memread;

	// Execute/memory register
	always_ff @(posedge clk) begin
		if (reset)
			{m_regwrite, m_memread, m_memwrite} <= '0;
		else if (!mem_stall)
			{m_regwrite, m_memread, m_memwrite} <= {e_regwrite, e_memread, e_memwrite};
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			m_result <= ex_result;
			m_store_data <= e_rt_data;
			m_wreg <= ex_wreg;
		end
	end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          jump_taken,
	input  logic [cpu_pipe_pkg::xlen-1:0] jump_target,
	input  logic                          branch_taken,
	input  logic [cpu_pipe_pkg::xlen-1:0] branch_target,
	input  logic                          load_stall,
	input  logic                          mem_stall,
	input  logic [cpu_pipe_pkg::xlen-1:0] imem_data,
	output logic [cpu_pipe_pkg::xlen-1:0] imem_addr,
	output logic [cpu_pipe_pkg::xlen-1:0] d_instr,
	output logic [cpu_pipe_pkg::xlen-1:0] d_pc_next
);

	logic [cpu_pipe_pkg::xlen-1:0] pc;
	logic [cpu_pipe_pkg::xlen-1:0] pc_plus4;
	logic [cpu_pipe_pkg::xlen-1:0] pc_next;

	assign imem_addr = pc;
	assign pc_plus4 = pc + 4;

	// Older instruction wins, so the branch goes first
	assign pc_next = branch_taken ? branch_target :
		jump_taken ? jump_target : pc_plus4;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= cpu_pipe_pkg::reset_pc;
		else if (!(mem_stall || load_stall))
			pc <= pc_next;
	end

	// Fetch/decode register, a zero word decodes as a nop
	always_ff @(posedge clk) begin
		if (reset)
			d_instr <= '0;
		else if (!mem_stall) begin
			if (jump_taken || branch_taken)
				d_instr <= '0;
			else if (!load_stall)
				d_instr <= imem_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!(mem_stall || load_stall))
			d_pc_next <= pc_plus4;
	end

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                m_regwrite,
	input  logic                                m_memread,
	input  logic                                m_memwrite,
	input  logic [cpu_pipe_pkg::xlen-1:0]       m_result,
	input  logic [cpu_pipe_pkg::xlen-1:0]       m_store_data,
	input  logic [cpu_pipe_pkg::reg_addr_w-1:0] m_wreg,
	input  logic [cpu_pipe_pkg::xlen-1:0]       mem_data_out,
	input  logic                                mem_ack,
	output logic                                mem_enable,
	output logic                                mem_rw,
	output logic [cpu_pipe_pkg::xlen-1:0]       mem_addr,
	output logic [cpu_pipe_pkg::xlen-1:0]       mem_data_in,
	output logic                                mem_stall,
	output logic [cpu_pipe_pkg::xlen-1:0]       mem_fwd_data,
	output logic [cpu_pipe_pkg::reg_addr_w-1:0] mem_fwd_wreg,
	output logic                                mem_fwd_regwrite,
	output logic                                wb_regwrite,
	output logic [cpu_pipe_pkg::reg_addr_w-1:0] wb_wreg,
	output logic [cpu_pipe_pkg::xlen-1:0]       wb_wdata
);

	logic [cpu_pipe_pkg::xlen-1:0] wdata;

	// Request comes straight from the held execute/memory register
	assign mem_enable = m_memread || m_memwrite;
	assign mem_rw = m_memread;
	assign mem_addr = m_result;
	assign mem_data_in = m_store_data;

	// Released in the ack cycle so the pipe moves on at the next edge
	assign mem_stall = mem_enable && !mem_ack;

	assign wdata = m_memread ? mem_data_out : m_result;
	assign mem_fwd_data = wdata;
	assign mem_fwd_wreg = m_wreg;
	assign mem_fwd_regwrite = m_regwrite;

	// Memory/write-back register, bubble while waiting
	always_ff @(posedge clk) begin
		if (reset || mem_stall)
			wb_regwrite <= 1'b0;
		else
			wb_regwrite <= m_regwrite;
	end

	always_ff @(posedge clk) begin
		wb_wreg <= m_wreg;
		wb_wdata <= wdata;
	end

	a_req_stable: assert property (@(posedge clk) disable iff (reset)
		(mem_enable && !mem_ack) |=>
		(mem_enable && $stable(mem_addr) && $stable(mem_rw) && $stable(mem_data_in)));

endmodule

// File: testbench/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
	input logic                          clk,
	input logic                          mem_enable,
	input logic                          mem_rw,
	input logic                          mem_ack,
	input logic [cpu_pipe_pkg::xlen-1:0] mem_addr,
	input logic [cpu_pipe_pkg::xlen-1:0] mem_data_in
);

	// Store address that marks the end of a program
	localparam logic [31:0] end_addr = 32'hFFFF_FFF0;

	string name;
	logic [31:0] exp_addr [16];
	logic [31:0] exp_data [16];
	int exp_len;
	int seen;
	int errors;
	int passed;
	int failed;
	logic done;

	initial begin
		passed = 0;
		failed = 0;
		done = 1'b0;
	end

	task automatic start_test(input string test_name);
		name = test_name;
		exp_len = 0;
		seen = 0;
		errors = 0;
		done = 1'b0;
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr[exp_len] = addr;
		exp_data[exp_len] = data;
		exp_len++;
	endtask

	task automatic check_store();
		if (seen >= exp_len) begin
			$display("Test %s: extra store of %h to address %h", name, mem_data_in, mem_addr);
			errors++;
		end else begin
			if (mem_addr !== exp_addr[seen]) begin
				$display("Error: %s store %0d address expected %h actual %h",
					name, seen, exp_addr[seen], mem_addr);
				errors++;
			end
			if (mem_data_in !== exp_data[seen]) begin
				$display("Error: %s store %0d data expected %h actual %h",
					name, seen, exp_data[seen], mem_data_in);
				errors++;
			end
		end
		seen++;
	endtask

	task automatic close_test();
		if (seen < exp_len) begin
			$display("Test %s: %0d of %0d expected stores never appeared",
				name, exp_len - seen, exp_len);
			errors++;
		end
		if (errors == 0) begin
			$display("Test %s passed, %0d stores checked", name, seen);
			passed++;
		end else begin
			$display("Test %s failed with %0d errors", name, errors);
			failed++;
		end
		done = 1'b1;
	endtask

	// Acked stores, sampled mid-cycle
	always @(negedge clk) begin
		if (!done && mem_enable === 1'b1 && mem_ack === 1'b1 && mem_rw === 1'b0) begin
			if (mem_addr == end_addr)
				close_test();
			else
				check_store();
		end
	end

endmodule

// File: testbench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

	localparam int num_tests = 5;
	localparam int max_words = 32;
	localparam int max_stores = 16;

	logic clk;
	logic reset;
	logic [cpu_pipe_pkg::xlen-1:0] imem_addr;
	logic [cpu_pipe_pkg::xlen-1:0] imem_data;
	logic mem_enable;
	logic mem_rw;
	logic mem_ack;
	logic [cpu_pipe_pkg::xlen-1:0] mem_addr;
	logic [cpu_pipe_pkg::xlen-1:0] mem_data_in;
	logic [cpu_pipe_pkg::xlen-1:0] mem_data_out;

	// Test table
	string test_name [num_tests];
	bit random_ack [num_tests];
	logic [31:0] prog [num_tests][max_words];
	int prog_len [num_tests];
	logic [31:0] store_addr [num_tests][max_stores];
	logic [31:0] store_data [num_tests][max_stores];
	int store_len [num_tests];
	int n_tests;
	int cur;

	logic [31:0] dmem [64];
	logic [15:0] lfsr;
	bit pending;
	int wait_left;
	int cycles;
	int cycle_limit;

	cpu cpu_i (
		.clk, .reset, .imem_addr, .imem_data,
		.mem_enable, .mem_rw, .mem_addr, .mem_data_in, .mem_data_out, .mem_ack
	);

	cpu_checker cpu_checker_i (
		.clk, .mem_enable, .mem_rw, .mem_ack, .mem_addr, .mem_data_in
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////

	function automatic logic [31:0] r_word(input logic [5:0] funct,
		input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
		cpu_isa_pkg::instr_t w;
		w = '0;
		w.r.opcode = cpu_isa_pkg::op_special;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op,
		input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
		cpu_isa_pkg::instr_t w;
		w.i.opcode = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic logic [31:0] j_word(input logic [25:0] target);
		cpu_isa_pkg::instr_t w;
		w.j.opcode = cpu_isa_pkg::op_j;
		w.j.target = target;
		return w;
	endfunction

	// 16-bit Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	////////////////////////////////////////
	// Table building
	////////////////////////////////////////

	task automatic new_test(input string name, input bit rand_mode);
		test_name[n_tests] = name;
		random_ack[n_tests] = rand_mode;
		n_tests++;
	endtask

	task automatic put(input logic [31:0] w);
		int t;
		t = n_tests - 1;
		prog[t][prog_len[t]] = w;
		prog_len[t]++;
	endtask

	task automatic want(input logic [31:0] addr, input logic [31:0] data);
		int t;
		t = n_tests - 1;
		store_addr[t][store_len[t]] = addr;
		store_data[t][store_len[t]] = data;
		store_len[t]++;
	endtask

	// End marker store, then a jump to itself
	task automatic end_program();
		put(i_word(cpu_isa_pkg::op_sw, 5'd0, 5'd0, 16'hFFF0));
		put(j_word(26'(prog_len[n_tests - 1])));
	endtask

	// Dependent chain hitting the execute, memory and write-back forwards
	task automatic arith_program();
		put(i_word(cpu_isa_pkg::op_addiu, 5'd1, 5'd0, 16'd5));
		put(i_word(cpu_isa_pkg::op_addiu, 5'd2, 5'd0, 16'hFFF7));
		put(r_word(cpu_isa_pkg::fn_addu, 5'd3, 5'd1, 5'd2));
		put(r_word(cpu_isa_pkg::fn_subu, 5'd4, 5'd3, 5'd1));
		put(r_word(cpu_isa_pkg::fn_and, 5'd5, 5'd4, 5'd3));
		put(r_word(cpu_isa_pkg::fn_or, 5'd6, 5'd5, 5'd1));
		put(r_word(cpu_isa_pkg::fn_slt, 5'd7, 5'd2, 5'd1));
		put(r_word(cpu_isa_pkg::fn_slt, 5'd8, 5'd1, 5'd6));
		put(i_word(cpu_isa_pkg::op_sw, 5'd8, 5'd0, 16'd20));
		for (int k = 3; k < 8; k++)
			put(i_word(cpu_isa_pkg::op_sw, 5'(k), 5'd0, 16'(4 * (k - 3))));
		end_program();
		// 5 < -11 is false
		want(32'd20, 32'd0);
		want(32'd0, 32'hFFFF_FFFC);
		want(32'd4, 32'hFFFF_FFF7);
		want(32'd8, 32'hFFFF_FFF4);
		want(32'd12, 32'hFFFF_FFF5);
		want(32'd16, 32'd1);
	endtask

	task automatic build_table();
		new_test("alu_forwarding", 1'b0);
		arith_program();

		new_test("load_use", 1'b0);
		put(i_word(cpu_isa_pkg::op_addiu, 5'd1, 5'd0, 16'h1234));
		put(i_word(cpu_isa_pkg::op_sw, 5'd1, 5'd0, 16'd8));
		put(i_word(cpu_isa_pkg::op_lw, 5'd2, 5'd0, 16'd8));
		put(r_word(cpu_isa_pkg::fn_addu, 5'd3, 5'd2, 5'd2));
		put(i_word(cpu_isa_pkg::op_sw, 5'd3, 5'd0, 16'd12));
		put(i_word(cpu_isa_pkg::op_lw, 5'd4, 5'd0, 16'd12));
		put(i_word(cpu_isa_pkg::op_sw, 5'd4, 5'd0, 16'd16));
		end_program();
		want(32'd8, 32'h1234);
		want(32'd12, 32'h2468);
		want(32'd16, 32'h2468);

		new_test("beq_taken_not_taken", 1'b0);
		put(i_word(cpu_isa_pkg::op_addiu, 5'd1, 5'd0, 16'd7));
		put(i_word(cpu_isa_pkg::op_addiu, 5'd2, 5'd0, 16'd7));
		put(i_word(cpu_isa_pkg::op_beq, 5'd2, 5'd1, 16'd2));
		put(i_word(cpu_isa_pkg::op_sw, 5'd1, 5'd0, 16'd0));
		put(i_word(cpu_isa_pkg::op_sw, 5'd2, 5'd0, 16'd4));
		put(i_word(cpu_isa_pkg::op_beq, 5'd0, 5'd1, 16'd1));
		put(i_word(cpu_isa_pkg::op_sw, 5'd1, 5'd0, 16'd8));
		put(i_word(cpu_isa_pkg::op_sw, 5'd2, 5'd0, 16'd12));
		end_program();
		want(32'd8, 32'd7);
		want(32'd12, 32'd7);

		new_test("jump_over_stores", 1'b0);
		put(i_word(cpu_isa_pkg::op_addiu, 5'd1, 5'd0, 16'h0055));
		put(j_word(26'd4));
		put(i_word(cpu_isa_pkg::op_sw, 5'd1, 5'd0, 16'd0));
		put(i_word(cpu_isa_pkg::op_sw, 5'd1, 5'd0, 16'd4));
		put(i_word(cpu_isa_pkg::op_sw, 5'd1, 5'd0, 16'd8));
		end_program();
		want(32'd8, 32'h55);

		new_test("alu_random_ack", 1'b1);
		arith_program();
	endtask

	////////////////////////////////////////
	// Memory models
	////////////////////////////////////////

	always_comb begin
		if (imem_addr[31:2] < prog_len[cur])
			imem_data = prog[cur][imem_addr[6:2]];
		else
			imem_data = '0;
	end

	// Ack 0 to 3 cycles after the request shows up
	always @(posedge clk) begin
		#1;
		mem_ack <= 1'b0;
		if (mem_enable === 1'b1) begin
			if (!pending) begin
				pending = 1'b1;
				wait_left = 0;
				if (random_ack[cur]) begin
					for (int b = 0; b < 2; b++) begin
						wait_left = 2 * wait_left + lfsr[0];
						lfsr = lfsr_step(lfsr);
					end
				end
			end
			if (wait_left == 0) begin
				pending = 1'b0;
				mem_ack <= 1'b1;
				if (mem_rw)
					mem_data_out <= dmem[mem_addr[7:2]];
				else
					dmem[mem_addr[7:2]] = mem_data_in;
			end else begin
				wait_left--;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: test %s never reached its final store after %0d cycles",
				test_name[cur], cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic run_test(input int t);
		@(posedge clk);
		#1;
		reset = 1'b1;
		cur = t;
		for (int k = 0; k < 64; k++)
			dmem[k] = '0;
		cpu_checker_i.start_test(test_name[t]);
		for (int k = 0; k < store_len[t]; k++)
			cpu_checker_i.expect_store(store_addr[t][k], store_data[t][k]);
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		while (!cpu_checker_i.done)
			@(posedge clk);
	endtask

	initial begin
		reset = 1'b1;
		mem_ack = 1'b0;
		mem_data_out = '0;
		lfsr = 16'd34614;
		pending = 1'b0;
		wait_left = 0;
		cur = 0;
		cycles = 0;
		n_tests = 0;
		build_table();
		cycle_limit = 200;
		for (int t = 0; t < n_tests; t++)
			cycle_limit += 40 * prog_len[t];
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("Tests passed: %0d, failed: %0d", cpu_checker_i.passed, cpu_checker_i.failed);
		if (cpu_checker_i.failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
